/* compile.f */
source/fdc_pkg.sv
source/fdc_cmd_decode.sv
source/fdc_cmd_exec.sv
source/fdc_result_port.sv
source/fdc_top.sv
verification/tb_clock_gen.sv
verification/fdc_sva.sv
verification/fdc_tb.sv

/* Bender.yml */
package:
  name: fdc

sources:
  - source/fdc_pkg.sv
  - source/fdc_cmd_decode.sv
  - source/fdc_cmd_exec.sv
  - source/fdc_result_port.sv
  - source/fdc_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/fdc_sva.sv
      - verification/fdc_tb.sv

/* verification/fdc_tb.sv */
/*
 * fdc testbench top
 * host bus tasks, command sequences and the run summary
 */
`timescale 1ns/1ps

module fdc_tb;
	import fdc_pkg::*;

	localparam int TIMEOUT_CYCLES = 2000;	// tests need a few hundred cycles

	logic       clk_sys;
	logic       rst_n;
	logic       wr_en;
	logic       rd_en;
	logic       a0;
	logic       drive_ready;
	logic [7:0] din;
	logic [7:0] dout;

	int seed = 80690;
	int cycles = 0;
	int errors = 0;
	int err_base = 0;	// errors when the current test began
	int tests_run = 0;
	int tests_failed = 0;

	tb_clock_gen clk_gen (
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	fdc_top dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.rd_en       (rd_en),
		.a0          (a0),
		.din         (din),
		.dout        (dout),
		.drive_ready (drive_ready)
	);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// ======================================================================
	// host bus tasks start and end 1 ns after a rising edge
	// ======================================================================
	task automatic host_write(input logic addr, input logic [7:0] data);
		wr_en = 1'b1;
		a0 = addr;
		din = data;
		@(posedge clk_sys);
		#1;
		wr_en = 1'b0;
	endtask

	task automatic host_read(input logic addr, output logic [7:0] data);
		rd_en = 1'b1;
		a0 = addr;
		@(posedge clk_sys);
		#1;
		rd_en = 1'b0;
		data = dout;	// registered in the cycle after rd_en
	endtask

	task automatic wait_rqm(output logic [7:0] msr);
		host_read(1'b0, msr);
		while (!msr[MSR_RQM])
			host_read(1'b0, msr);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		assert (got === exp) else begin
			$display("MISMATCH at %0d ns: %s read %02h, expected %02h",
				$time, what, got, exp);
			errors++;
		end
	endtask

	task automatic send_cmd(input logic [7:0] opc, input int n_par, input logic [7:0] p0,
			input logic [7:0] p1, output logic [7:0] msr);
		host_write(1'b1, opc);
		if (n_par > 0)
			host_write(1'b1, p0);
		if (n_par > 1)
			host_write(1'b1, p1);
		wait_rqm(msr);
	endtask

	// command without a result phase leaves status idle
	task automatic run_plain(input logic [7:0] opc, input int n_par, input logic [7:0] p0,
			input logic [7:0] p1, input string what);
		logic [7:0] msr;
		send_cmd(opc, n_par, p0, p1, msr);
		check_byte(msr, 8'h80, {what, " status"});
	endtask

	task automatic run_result(input logic [7:0] opc, input int n_par, input logic [7:0] p0,
			input int n_res, input logic [7:0] exp0, input logic [7:0] exp1,
			input string what);
		logic [7:0] msr;
		logic [7:0] b;
		send_cmd(opc, n_par, p0, 8'h00, msr);
		check_byte(msr, 8'hD0, {what, " status"});	// RQM, DIO, CB
		host_read(1'b1, b);
		check_byte(b, exp0, {what, " byte 0"});
		if (n_res > 1) begin
			host_read(1'b1, b);
			check_byte(b, exp1, {what, " byte 1"});
		end
		host_read(1'b0, msr);
		check_byte(msr, 8'h80, {what, " final status"});
	endtask

	// status 3 as the drive should report it
	function automatic logic [7:0] expected_st3(input logic rdy, input logic [7:0] cyl,
			input logic [7:0] sel);
		return {2'b00, rdy, cyl == 8'd0, TWO_SIDED, sel[2], sel[1:0]};
	endfunction

	task automatic end_test(input string name);
		int total;
		total = errors + dut.u_sva.fail_cnt;
		tests_run++;
		if (total == err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, total - err_base);
		end
		err_base = total;
	endtask

	// ======================================================================
	// tests
	// ======================================================================
	initial begin
		logic [7:0] msr;
		logic [7:0] b;
		logic [7:0] sel;
		logic [7:0] cyl;
		logic [7:0] prev_cyl;
		logic [1:0] unit;
		wr_en = 1'b0;
		rd_en = 1'b0;
		a0 = 1'b0;
		din = 8'h00;
		drive_ready = 1'b1;
		@(posedge rst_n);
		@(posedge clk_sys);
		#1;

		host_read(1'b0, msr);
		check_byte(msr, 8'h80, "status after reset");
		run_plain({3'b000, OPC_SPECIFY}, 2, 8'hAF, 8'h02, "SPECIFY");
		end_test("reset and SPECIFY");

		// unknown code then a known code with flag bits
		run_result(8'h1F, 0, 8'h00, 1, 8'h80, 8'h00, "unknown opcode");
		run_result(8'hE3, 0, 8'h00, 1, 8'h80, 8'h00, "opcode with flags");
		end_test("invalid opcode");

		unit = 2'($random(seed));
		cyl = 8'($unsigned($random(seed)) % 40);
		sel = {5'b00000, 1'b1, unit};
		run_plain({3'b000, OPC_SEEK}, 2, sel, cyl, "SEEK");
		run_result({3'b000, OPC_SENSE_INT}, 0, 8'h00, 2, 8'h20 | unit, cyl, "SENSE INT");
		run_plain({3'b000, OPC_RECAL}, 1, sel, 8'h00, "RECAL");
		run_result({3'b000, OPC_SENSE_INT}, 0, 8'h00, 2, 8'h20 | unit, 8'h00, "SENSE INT");
		end_test("SEEK and RECAL");

		unit = 2'($random(seed));
		sel = {6'b000000, unit};
		prev_cyl = 8'(1 + $unsigned($random(seed)) % 39);	// nonzero and reused below
		run_plain({3'b000, OPC_SEEK}, 2, sel, prev_cyl, "SEEK");
		run_result({3'b000, OPC_SENSE_INT}, 0, 8'h00, 2, 8'h20 | unit, prev_cyl, "SENSE INT");
		cyl = 8'(40 + $unsigned($random(seed)) % 216);
		run_plain({3'b000, OPC_SEEK}, 2, sel, cyl, "SEEK past limit");
		run_result({3'b000, OPC_SENSE_INT}, 0, 8'h00, 2, 8'h70 | unit, prev_cyl,
			"SENSE INT after seek error");
		end_test("seek error");

		run_result({3'b000, OPC_SENSE_INT}, 0, 8'h00, 1, 8'h80, 8'h00, "SENSE INT idle");
		host_read(1'b1, b);
		check_byte(b, 8'hFF, "data read with no result");
		end_test("SENSE INT with nothing pending");

		// cylinder still prev_cyl here
		sel = {5'b00000, 1'b1, 2'd2};
		drive_ready = 1'b1;
		run_result({3'b000, OPC_SENSE_DRIVE}, 1, sel, 1, expected_st3(1'b1, prev_cyl, sel),
			8'h00, "SENSE DRIVE ready");
		drive_ready = 1'b0;
		run_result({3'b000, OPC_SENSE_DRIVE}, 1, sel, 1, expected_st3(1'b0, prev_cyl, sel),
			8'h00, "SENSE DRIVE not ready");
		run_plain({3'b000, OPC_RECAL}, 1, sel, 8'h00, "RECAL");
		run_result({3'b000, OPC_SENSE_DRIVE}, 1, sel, 1, expected_st3(1'b0, 8'h00, sel),
			8'h00, "SENSE DRIVE track 0");
		sel = {5'b00000, 1'b0, 2'd1};
		drive_ready = 1'b1;
		run_result({3'b000, OPC_SENSE_DRIVE}, 1, sel, 1, expected_st3(1'b1, 8'h00, sel),
			8'h00, "SENSE DRIVE track 0 ready");
		end_test("SENSE DRIVE");

		$display("summary: %0d tests, %0d failed, %0d value errors, %0d assertion failures",
			tests_run, tests_failed, errors, dut.u_sva.fail_cnt);
		if (errors == 0 && tests_failed == 0 && dut.u_sva.fail_cnt == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verification/fdc_sva.sv */
/*
 * fdc protocol checks, bound into the controller top
 * command and result handshakes, status bits and cylinder range
 */
`timescale 1ns/1ps

module fdc_sva (
	input logic                clk_sys,
	input logic                rst_n,
	input logic                cmd_valid,
	input logic                cmd_ready,
	input fdc_pkg::fdc_cmd_e   cmd_code,
	input fdc_pkg::fdc_param_u cmd_sel,
	input fdc_pkg::fdc_param_u cmd_cyl,
	input logic                res_valid,
	input logic                res_ready,
	input logic                dio,
	input logic                cb,
	input logic [7:0]          pcn
);
	import fdc_pkg::*;

	int fail_cnt = 0;	// failed assertions so far

	// decode holds the command until exec takes it
	a_cmd_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_code)
			&& $stable(cmd_sel) && $stable(cmd_cyl))
	else begin
		$error("command withdrawn or changed before cmd_ready");
		fail_cnt++;
	end

	a_res_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid)
	else begin
		$error("result withdrawn before res_ready");
		fail_cnt++;
	end

	// result bytes only exist inside a command
	a_dio_cb: assert property (@(posedge clk_sys) disable iff (!rst_n) !(dio && !cb))
	else begin
		$error("DIO set while CB is clear");
		fail_cnt++;
	end

	a_pcn_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pcn < MAX_CYLINDERS)
	else begin
		$error("present cylinder at or above the track limit");
		fail_cnt++;
	end

endmodule

bind fdc_top fdc_sva u_sva (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.cmd_valid (cmd_valid),
	.cmd_ready (cmd_ready),
	.cmd_code  (cmd_code),
	.cmd_sel   (cmd_sel),
	.cmd_cyl   (cmd_cyl),
	.res_valid (res_valid),
	.res_ready (res_ready),
	.dio       (u_result.dio),
	.cb        (u_result.cb),
	.pcn       (u_exec.pcn)
);

/* verification/tb_clock_gen.sv */
/*
 * testbench clock and reset
 * 10 ns clock, reset held low over the first three rising edges
 */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_sys,
	output logic rst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;	// 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;	// released just after the third edge
	end

endmodule

/* source/fdc_top.sv */
/*
 * floppy disk controller, host side
 * decoder, executor and result port in a chain
 */
`timescale 1ns/1ps

module fdc_top (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       wr_en,
	input  logic       rd_en,
	input  logic       a0,
	input  logic [7:0] din,
	output logic [7:0] dout,
	input  logic       drive_ready
);
	import fdc_pkg::*;

	// decode to exec
	logic       cmd_start;
	logic       cmd_valid;
	logic       cmd_ready;
	fdc_cmd_e   cmd_code;
	fdc_param_u cmd_sel;
	fdc_param_u cmd_cyl;

	// exec to result port
	logic                                 res_valid;
	logic                                 res_ready;
	logic [$clog2(MAX_RESULT_BYTES+1)-1:0] res_count;
	logic [7:0]                           res_byte0;
	logic [7:0]                           res_byte1;
	logic                                 host_busy;

	fdc_cmd_decode u_decode (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.a0        (a0),
		.din       (din),
		.host_busy (host_busy),
		.cmd_ready (cmd_ready),
		.cmd_start (cmd_start),
		.cmd_valid (cmd_valid),
		.cmd_code  (cmd_code),
		.cmd_sel   (cmd_sel),
		.cmd_cyl   (cmd_cyl)
	);

	fdc_cmd_exec u_exec (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_code    (cmd_code),
		.cmd_sel     (cmd_sel),
		.cmd_cyl     (cmd_cyl),
		.drive_ready (drive_ready),
		.res_ready   (res_ready),
		.cmd_ready   (cmd_ready),
		.res_valid   (res_valid),
		.res_count   (res_count),
		.res_byte0   (res_byte0),
		.res_byte1   (res_byte1)
	);

	fdc_result_port u_result (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rd_en     (rd_en),
		.a0        (a0),
		.cmd_start (cmd_start),
		.res_valid (res_valid),
		.res_count (res_count),
		.res_byte0 (res_byte0),
		.res_byte1 (res_byte1),
		.res_ready (res_ready),
		.host_busy (host_busy),
		.dout      (dout)
	);

endmodule

/* source/fdc_result_port.sv */
/*
 * fdc result port
 * main status register, result byte sequencing and host read data
 */
`timescale 1ns/1ps

module fdc_result_port (
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        rd_en,
	input  logic        a0,
	input  logic        cmd_start,
	input  logic        res_valid,
	input  logic [$clog2(fdc_pkg::MAX_RESULT_BYTES+1)-1:0] res_count,
	input  logic [7:0]  res_byte0,
	input  logic [7:0]  res_byte1,
	output logic        res_ready,
	output logic        host_busy,
	output logic [7:0]  dout
);
	import fdc_pkg::*;

	localparam int CNT_W = $clog2(MAX_RESULT_BYTES + 1);

	logic             cb;	// command busy
	logic [CNT_W-1:0] res_left;	// result bytes not yet read
	logic [7:0]       res_q0;	// next byte for the host
	logic [7:0]       res_q1;
	logic             dio;
	logic             rqm;
	logic [7:0]       msr;
	logic             res_take;
	logic             data_rd;

	assign res_ready = (res_left == '0);
	assign res_take  = res_valid && res_ready;
	assign data_rd   = rd_en && a0;
	assign dio       = (res_left != '0);
	// command phase holds RQM low until the result or the end of the command
	assign rqm       = !(cb && !dio);
	assign host_busy = cb;

	always_comb begin
		msr = 8'h00;
		msr[MSR_RQM] = rqm;
		msr[MSR_DIO] = dio;
		msr[MSR_CB]  = cb;
	end

	// ======================================================================
	// busy flag and byte counter
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cb <= 1'b0;
			res_left <= '0;
		end else begin
			if (cmd_start)
				cb <= 1'b1;
			if (res_take) begin
				res_left <= res_count;
				if (res_count == '0)
					cb <= 1'b0;	// no result phase
			end else if (data_rd && dio) begin
				res_left <= res_left - CNT_W'(1);
				if (res_left == CNT_W'(1))
					cb <= 1'b0;	// last byte read
			end
		end
	end

	// result bytes shift toward the host, read data registered
	always_ff @(posedge clk_sys) begin
		if (res_take) begin
			res_q0 <= res_byte0;
			res_q1 <= res_byte1;
		end else if (data_rd && dio) begin
			res_q0 <= res_q1;
		end
		if (rd_en) begin
			if (!a0)
				dout <= msr;
			else
				dout <= dio ? res_q0 : 8'hFF;
		end
	end

endmodule

/* source/fdc_cmd_exec.sv */
/*
 * fdc command executor
 * runs the kept commands, tracks cylinder and interrupt state
 */
`timescale 1ns/1ps

module fdc_cmd_exec (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 cmd_valid,
	input  fdc_pkg::fdc_cmd_e    cmd_code,
	input  fdc_pkg::fdc_param_u  cmd_sel,
	input  fdc_pkg::fdc_param_u  cmd_cyl,
	input  logic                 drive_ready,
	input  logic                 res_ready,
	output logic                 cmd_ready,
	output logic                 res_valid,
	output logic [$clog2(fdc_pkg::MAX_RESULT_BYTES+1)-1:0] res_count,
	output logic [7:0]           res_byte0,
	output logic [7:0]           res_byte1
);
	import fdc_pkg::*;

	localparam int CNT_W = $clog2(MAX_RESULT_BYTES + 1);

	logic [7:0] pcn;	// present cylinder
	logic [7:0] st0;	// status 0 of the last seek or recal
	logic       int_pend;
	logic [7:0] st3;
	logic [7:0] unit_bits;
	logic       cmd_fire;

	// no new command while a result is offered or the host is still reading one
	assign cmd_ready = res_ready && !res_valid;
	assign cmd_fire  = cmd_valid && cmd_ready;
	assign unit_bits = {6'd0, cmd_sel.sel.unit};

	always_comb begin
		st3 = 8'h00;
		st3[ST3_RDY] = drive_ready;
		st3[ST3_T0]  = (pcn == 8'd0);
		st3[ST3_TS]  = TWO_SIDED;
		st3[ST3_HD]  = cmd_sel.sel.head;
		st3[1:0]     = cmd_sel.sel.unit;
	end

	// ======================================================================
	// drive state and result handshake
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			pcn <= 8'd0;
			st0 <= 8'h00;
			int_pend <= 1'b0;
		end else begin
			if (res_valid && res_ready)
				res_valid <= 1'b0;
			if (cmd_fire) begin
				res_valid <= 1'b1;
				case (cmd_code)
					CMD_SEEK: begin
						int_pend <= 1'b1;
						if (cmd_cyl.cyl < MAX_CYLINDERS) begin
							pcn <= cmd_cyl.cyl;
							st0 <= ST0_SEEK_END | unit_bits;
						end else begin
							st0 <= ST0_SEEK_ERR | unit_bits;	// cylinder kept
						end
					end
					CMD_RECAL: begin
						int_pend <= 1'b1;
						pcn <= 8'd0;
						st0 <= ST0_SEEK_END | unit_bits;
					end
					CMD_SENSE_INT: int_pend <= 1'b0;
					default: ;
				endcase
			end
		end
	end

	// result bytes
	always_ff @(posedge clk_sys) begin
		if (cmd_fire) begin
			res_count <= CNT_W'(0);
			res_byte0 <= ST0_INVALID;
			res_byte1 <= pcn;
			case (cmd_code)
				CMD_SENSE_DRIVE: begin
					res_count <= CNT_W'(1);
					res_byte0 <= st3;
				end
				CMD_SENSE_INT: begin
					if (int_pend) begin
						res_count <= CNT_W'(2);
						res_byte0 <= st0;
					end else begin
						res_count <= CNT_W'(1);	// nothing pending, acts as invalid
					end
				end
				CMD_INVALID: res_count <= CNT_W'(1);
				default: ;
			endcase
		end
	end

endmodule

/* source/fdc_cmd_decode.sv */
/*
 * fdc command decoder
 * matches the opcode byte, collects parameter bytes, offers the command
 */
`timescale 1ns/1ps

module fdc_cmd_decode (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  logic                 wr_en,
	input  logic                 a0,
	input  logic [7:0]           din,
	input  logic                 host_busy,
	input  logic                 cmd_ready,
	output logic                 cmd_start,
	output logic                 cmd_valid,
	output fdc_pkg::fdc_cmd_e    cmd_code,
	output fdc_pkg::fdc_param_u  cmd_sel,
	output fdc_pkg::fdc_param_u  cmd_cyl
);
	import fdc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PARAM,
		ST_OFFER
	} dec_state_e;

	dec_state_e state;
	logic [1:0] param_left;	// parameter bytes still expected
	logic       got_sel;	// first parameter byte already stored
	fdc_cmd_e   opc_code;
	logic [1:0] opc_params;
	logic       param_wr;

	// opcode lookup, any flag bit set makes it invalid
	always_comb begin
		opc_code = CMD_INVALID;
		opc_params = 2'd0;
		if (din[7:5] == 3'b000) begin
			case (din[4:0])
				OPC_SPECIFY: begin
					opc_code = CMD_SPECIFY;
					opc_params = 2'd2;
				end
				OPC_SEEK: begin
					opc_code = CMD_SEEK;
					opc_params = 2'd2;
				end
				OPC_SENSE_DRIVE: begin
					opc_code = CMD_SENSE_DRIVE;
					opc_params = 2'd1;
				end
				OPC_RECAL: begin
					opc_code = CMD_RECAL;
					opc_params = 2'd1;
				end
				OPC_SENSE_INT: opc_code = CMD_SENSE_INT;
				default: ;
			endcase
		end
	end

	// busy only blocks new opcodes, parameter bytes belong to the running command
	assign cmd_start = (state == ST_IDLE) && wr_en && a0 && !host_busy;
	assign param_wr  = (state == ST_PARAM) && wr_en && a0;
	assign cmd_valid = (state == ST_OFFER);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			param_left <= 2'd0;
			got_sel <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (cmd_start) begin
					param_left <= opc_params;
					got_sel <= 1'b0;
					state <= (opc_params == 2'd0) ? ST_OFFER : ST_PARAM;
				end
				ST_PARAM: if (param_wr) begin
					got_sel <= 1'b1;
					param_left <= param_left - 2'd1;
					if (param_left == 2'd1)
						state <= ST_OFFER;
				end
				ST_OFFER: if (cmd_ready) state <= ST_IDLE;	// handed to exec
				default: state <= ST_IDLE;
			endcase
		end
	end

	// command fields
	always_ff @(posedge clk_sys) begin
		if (cmd_start)
			cmd_code <= opc_code;
		if (param_wr) begin
			if (got_sel)
				cmd_cyl <= din;	// second byte, cylinder for SEEK
			else
				cmd_sel <= din;
		end
	end

endmodule

/* source/fdc_pkg.sv */
/*
 * fdc shared definitions
 * opcodes, status bit positions and values, command and parameter types
 */
package fdc_pkg;

	// ======================================================================
	// command opcodes, low five bits of the command byte
	// ======================================================================
	localparam logic [4:0] OPC_SPECIFY     = 5'h03;
	localparam logic [4:0] OPC_SENSE_DRIVE = 5'h04;
	localparam logic [4:0] OPC_SENSE_INT   = 5'h08;
	localparam logic [4:0] OPC_SEEK        = 5'h0F;
	localparam logic [4:0] OPC_RECAL       = 5'h07;

	// main status register bits
	localparam int MSR_RQM = 7;	// request for master
	localparam int MSR_DIO = 6;	// 1 = controller to host
	localparam int MSR_CB  = 4;	// command busy

	// status 0 values, unit select is ORed in
	localparam logic [7:0] ST0_SEEK_END = 8'h20;
	localparam logic [7:0] ST0_SEEK_ERR = 8'h70;	// abnormal end + seek end + equip check
	localparam logic [7:0] ST0_INVALID  = 8'h80;

	// status 3 bits
	localparam int ST3_RDY = 5;
	localparam int ST3_T0  = 4;
	localparam int ST3_TS  = 3;
	localparam int ST3_HD  = 2;

	// ======================================================================
	// drive geometry and result sizing
	// ======================================================================
	localparam logic [7:0] MAX_CYLINDERS    = 8'd40;
	localparam logic       TWO_SIDED        = 1'b1;
	localparam int         MAX_RESULT_BYTES = 2;

	typedef enum logic [2:0] {
		CMD_SPECIFY,
		CMD_SENSE_DRIVE,
		CMD_SENSE_INT,
		CMD_SEEK,
		CMD_RECAL,
		CMD_INVALID
	} fdc_cmd_e;

	// parameter byte, a drive/head select or a cylinder number
	typedef union packed {
		struct packed {
			logic [4:0] unused;
			logic       head;
			logic [1:0] unit;
		} sel;
		logic [7:0] cyl;
	} fdc_param_u;

endpackage
